// File: common/mem_pkg.sv
// Shared widths, address map, latency and arbiter states, used by scoped name in every module
package mem_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_sel_t;

    // Memory sizes in words
    localparam int MEM_WORDS  = 1024;
    localparam int BOOT_WORDS = 64;

    // Word index widths derived from the sizes
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int BOOT_IDX_W = $clog2(BOOT_WORDS);

    typedef logic [MEM_IDX_W-1:0]  mem_idx_t;
    typedef logic [BOOT_IDX_W-1:0] boot_idx_t;

    // Fetch addresses with this upper nibble go to boot memory
    localparam int           BOOT_SEL_HIGH   = 31;
    localparam int           BOOT_SEL_LOW    = 28;
    localparam logic [3:0]   BOOT_ADDR_MATCH = 4'h1;

    // Cycles from the first sight of mem_req to mem_ack
    localparam int MEM_LATENCY   = 3;
    localparam int MEM_LAT_CNT_W = $clog2(MEM_LATENCY + 1);

    typedef logic [MEM_LAT_CNT_W-1:0] lat_cnt_t;

    // Data port arbiter: one owner at a time
    typedef enum logic [1:0] {
        DATA_ARB_IDLE,
        DATA_ARB_LSU,
        DATA_ARB_MMU
    } data_arb_state_e;

    // Memory arbiter in front of main memory
    typedef enum logic [1:0] {
        MEM_ARB_IDLE,
        MEM_ARB_DATA,
        MEM_ARB_INSTR,
        MEM_ARB_KILL
    } mem_arb_state_e;

endpackage : mem_pkg

// File: logic/data_port_arbiter.sv
// Grants the load/store bus or the page walker the single data request toward mem_arbiter
`timescale 1ns/1ps

module data_port_arbiter (
    input  logic               clk,
    input  logic               rst_n,

    // Load/store bus
    input  logic               dbus_req_i,
    input  logic               dmem_sel_i,
    input  mem_pkg::addr_t     dbus_addr_i,
    input  mem_pkg::word_t     dbus_wdata_i,
    input  logic               dbus_wen_i,
    input  mem_pkg::byte_sel_t dbus_byte_sel_i,
    output logic               dbus_ack_o,
    output mem_pkg::word_t     dbus_rdata_o,

    // Page walker reads
    input  logic               mmu_req_i,
    input  mem_pkg::addr_t     mmu_paddr_i,
    output logic               mmu_valid_o,
    output mem_pkg::word_t     mmu_rdata_o,

    // Merged data request
    output logic               data_req_o,
    output mem_pkg::addr_t     data_addr_o,
    output mem_pkg::word_t     data_wdata_o,
    output logic               data_wen_o,
    output mem_pkg::byte_sel_t data_byte_sel_o,
    input  logic               data_ack_i,
    input  mem_pkg::word_t     data_rdata_i
);

    mem_pkg::data_arb_state_e state_ff;
    mem_pkg::data_arb_state_e state_next;

    logic lsu_req;

    // A load/store access only counts when the decoder selects main memory
    assign lsu_req = dbus_req_i & dmem_sel_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_ff <= mem_pkg::DATA_ARB_IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    always_comb begin
        state_next      = state_ff;
        data_req_o      = 1'b0;
        data_addr_o     = '0;
        data_wdata_o    = '0;
        data_wen_o      = 1'b0;
        data_byte_sel_o = '0;
        dbus_ack_o      = 1'b0;
        dbus_rdata_o    = '0;
        mmu_valid_o     = 1'b0;
        mmu_rdata_o     = '0;

        // Route the request of whoever owns or is about to own the port
        if ((state_ff == mem_pkg::DATA_ARB_LSU) ||
            ((state_ff == mem_pkg::DATA_ARB_IDLE) && lsu_req)) begin
            data_req_o      = lsu_req;
            data_addr_o     = dbus_addr_i;
            data_wdata_o    = dbus_wdata_i;
            data_wen_o      = dbus_wen_i;
            data_byte_sel_o = dbus_byte_sel_i;
        end else if ((state_ff == mem_pkg::DATA_ARB_MMU) ||
                     ((state_ff == mem_pkg::DATA_ARB_IDLE) && mmu_req_i)) begin
            // Walker always reads a full word
            data_req_o      = 1'b1;
            data_addr_o     = mmu_paddr_i;
            data_byte_sel_o = 4'hf;
        end

        case (state_ff)
            mem_pkg::DATA_ARB_IDLE: begin
                if (lsu_req) begin
                    state_next = mem_pkg::DATA_ARB_LSU;
                end else if (mmu_req_i) begin
                    state_next = mem_pkg::DATA_ARB_MMU;
                end
            end
            mem_pkg::DATA_ARB_LSU: begin
                if (data_ack_i) begin
                    dbus_ack_o   = 1'b1;
                    dbus_rdata_o = data_rdata_i;
                    state_next   = mem_pkg::DATA_ARB_IDLE;
                end
            end
            mem_pkg::DATA_ARB_MMU: begin
                if (data_ack_i) begin
                    mmu_valid_o = 1'b1;
                    mmu_rdata_o = data_rdata_i;
                    state_next  = mem_pkg::DATA_ARB_IDLE;
                end
            end
            default: begin
                state_next = mem_pkg::DATA_ARB_IDLE;
            end
        endcase
    end

endmodule : data_port_arbiter

// File: logic/boot_mem.sv
// Dual-port boot RAM, written and read from the data bus and read by instruction fetch
`timescale 1ns/1ps

module boot_mem (
    input  logic               clk,
    input  logic               rst_n,

    // Data bus port
    input  logic               dbus_req_i,
    input  logic               bmem_sel_i,
    input  mem_pkg::addr_t     dbus_addr_i,
    input  mem_pkg::word_t     dbus_wdata_i,
    input  logic               dbus_wen_i,
    input  mem_pkg::byte_sel_t dbus_byte_sel_i,
    output logic               bmem_ack_o,
    output mem_pkg::word_t     bmem_rdata_o,

    // Fetch port
    input  logic               fetch_req_i,
    input  mem_pkg::addr_t     fetch_addr_i,
    output logic               fetch_ack_o,
    output mem_pkg::word_t     fetch_rdata_o
);

    mem_pkg::word_t     mem [mem_pkg::BOOT_WORDS];
    mem_pkg::boot_idx_t d_idx;
    mem_pkg::boot_idx_t f_idx;
    logic               d_access;
    logic               f_access;

    assign d_idx = dbus_addr_i[mem_pkg::BOOT_IDX_W+1:2];
    assign f_idx = fetch_addr_i[mem_pkg::BOOT_IDX_W+1:2];

    // Skip the cycle of our own ack so a held request is served once
    assign d_access = dbus_req_i & bmem_sel_i & ~bmem_ack_o;
    assign f_access = fetch_req_i & ~fetch_ack_o &
        (fetch_addr_i[mem_pkg::BOOT_SEL_HIGH:mem_pkg::BOOT_SEL_LOW] == mem_pkg::BOOT_ADDR_MATCH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bmem_ack_o  <= 1'b0;
            fetch_ack_o <= 1'b0;
        end else begin
            bmem_ack_o  <= d_access;
            fetch_ack_o <= f_access;
        end
    end

    always_ff @(posedge clk) begin
        if (d_access) begin
            if (dbus_wen_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (dbus_byte_sel_i[i]) begin
                        mem[d_idx][8*i +: 8] <= dbus_wdata_i[8*i +: 8];
                    end
                end
            end
            bmem_rdata_o <= mem[d_idx];
        end
        if (f_access) begin
            fetch_rdata_o <= mem[f_idx];
        end
    end

endmodule : boot_mem

// File: mem_arbiter/mem_arbiter.sv
// Arbitrates data and instruction requests onto main memory, data side first, and drains killed fetches
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               rst_n,

    // Data side from the data port arbiter
    input  logic               data_req_i,
    input  mem_pkg::addr_t     data_addr_i,
    input  mem_pkg::word_t     data_wdata_i,
    input  logic               data_wen_i,
    input  mem_pkg::byte_sel_t data_byte_sel_i,
    output logic               data_ack_o,
    output mem_pkg::word_t     data_rdata_o,

    // Instruction side
    input  logic               instr_req_i,
    input  mem_pkg::addr_t     instr_addr_i,
    input  logic               instr_kill_i,
    output logic               instr_ack_o,
    output mem_pkg::word_t     instr_rdata_o,

    // Main memory
    output logic               mem_req_o,
    output mem_pkg::addr_t     mem_addr_o,
    output mem_pkg::word_t     mem_wdata_o,
    output logic               mem_wen_o,
    output mem_pkg::byte_sel_t mem_byte_sel_o,
    input  logic               mem_ack_i,
    input  mem_pkg::word_t     mem_rdata_i
);

    mem_pkg::mem_arb_state_e state_ff;
    mem_pkg::mem_arb_state_e state_next;

    // Fetch address captured at grant, held even if fetch moves on after a kill
    mem_pkg::addr_t instr_addr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_ff <= mem_pkg::MEM_ARB_IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state_ff == mem_pkg::MEM_ARB_IDLE) begin
            instr_addr_q <= instr_addr_i;
        end
    end

    always_comb begin
        state_next     = state_ff;
        mem_req_o      = 1'b0;
        mem_addr_o     = '0;
        mem_wdata_o    = '0;
        mem_wen_o      = 1'b0;
        mem_byte_sel_o = '0;
        data_ack_o     = 1'b0;
        data_rdata_o   = '0;
        instr_ack_o    = 1'b0;
        instr_rdata_o  = '0;

        case (state_ff)
            mem_pkg::MEM_ARB_IDLE: begin
                if (data_req_i) begin
                    mem_req_o      = 1'b1;
                    mem_addr_o     = data_addr_i;
                    mem_wdata_o    = data_wdata_i;
                    mem_wen_o      = data_wen_i;
                    mem_byte_sel_o = data_byte_sel_i;
                    state_next     = mem_pkg::MEM_ARB_DATA;
                end else if (instr_req_i && !instr_kill_i) begin
                    mem_req_o      = 1'b1;
                    mem_addr_o     = instr_addr_i;
                    mem_byte_sel_o = 4'hf;
                    state_next     = mem_pkg::MEM_ARB_INSTR;
                end
            end
            mem_pkg::MEM_ARB_DATA: begin
                if (mem_ack_i) begin
                    data_ack_o   = 1'b1;
                    data_rdata_o = mem_rdata_i;
                    state_next   = mem_pkg::MEM_ARB_IDLE;
                end else begin
                    mem_req_o      = 1'b1;
                    mem_addr_o     = data_addr_i;
                    mem_wdata_o    = data_wdata_i;
                    mem_wen_o      = data_wen_i;
                    mem_byte_sel_o = data_byte_sel_i;
                end
            end
            mem_pkg::MEM_ARB_INSTR: begin
                if (mem_ack_i) begin
                    // A kill landing on the ack cycle still swallows the ack
                    instr_ack_o   = !instr_kill_i;
                    instr_rdata_o = instr_kill_i ? '0 : mem_rdata_i;
                    state_next    = mem_pkg::MEM_ARB_IDLE;
                end else begin
                    mem_req_o      = 1'b1;
                    mem_addr_o     = instr_addr_q;
                    mem_byte_sel_o = 4'hf;
                    if (instr_kill_i) begin
                        state_next = mem_pkg::MEM_ARB_KILL;
                    end
                end
            end
            mem_pkg::MEM_ARB_KILL: begin
                // Memory is mid-transfer, let it finish and drop the result
                if (mem_ack_i) begin
                    state_next = mem_pkg::MEM_ARB_IDLE;
                end else begin
                    mem_req_o      = 1'b1;
                    mem_addr_o     = instr_addr_q;
                    mem_byte_sel_o = 4'hf;
                end
            end
            default: begin
                state_next = mem_pkg::MEM_ARB_IDLE;
            end
        endcase
    end

endmodule : mem_arbiter

// File: logic/main_mem.sv
// Word-addressed main memory with byte writes, acking a fixed number of cycles after a request
`timescale 1ns/1ps

module main_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_req_i,
    input  mem_pkg::addr_t     mem_addr_i,
    input  mem_pkg::word_t     mem_wdata_i,
    input  logic               mem_wen_i,
    input  mem_pkg::byte_sel_t mem_byte_sel_i,
    output logic               mem_ack_o,
    output mem_pkg::word_t     mem_rdata_o
);

    mem_pkg::word_t     mem [mem_pkg::MEM_WORDS];
    logic               busy_ff;
    mem_pkg::lat_cnt_t  cnt_ff;
    logic               accept;
    logic               finish;

    // Request captured at accept
    mem_pkg::mem_idx_t  idx_q;
    mem_pkg::word_t     wdata_q;
    logic               wen_q;
    mem_pkg::byte_sel_t byte_sel_q;

    assign accept = mem_req_i & ~busy_ff & ~mem_ack_o;
    assign finish = busy_ff & (cnt_ff == mem_pkg::lat_cnt_t'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_ff   <= 1'b0;
            cnt_ff    <= '0;
            mem_ack_o <= 1'b0;
        end else begin
            mem_ack_o <= finish;
            if (accept) begin
                busy_ff <= 1'b1;
                cnt_ff  <= mem_pkg::lat_cnt_t'(mem_pkg::MEM_LATENCY - 1);
            end else if (finish) begin
                busy_ff <= 1'b0;
                cnt_ff  <= '0;
            end else if (busy_ff) begin
                cnt_ff <= cnt_ff - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q      <= mem_addr_i[mem_pkg::MEM_IDX_W+1:2];
            wdata_q    <= mem_wdata_i;
            wen_q      <= mem_wen_i;
            byte_sel_q <= mem_byte_sel_i;
        end
        if (finish) begin
            if (wen_q) begin
                for (int i = 0; i < 4; i++) begin
                    if (byte_sel_q[i]) begin
                        mem[idx_q][8*i +: 8] <= wdata_q[8*i +: 8];
                    end
                end
            end
            mem_rdata_o <= mem[idx_q];
        end
    end

endmodule : main_mem

// File: logic/mem_top.sv
// Memory side top level joining fetch, boot memory, both arbiters and main memory
`timescale 1ns/1ps

module mem_top (
    input  logic               clk,
    input  logic               rst_n,

    // Instruction fetch
    input  logic               fetch_req_i,
    input  mem_pkg::addr_t     fetch_addr_i,
    input  logic               fetch_kill_i,
    output logic               fetch_ack_o,
    output mem_pkg::word_t     fetch_rdata_o,

    // Load/store bus and decoder selects
    input  logic               dbus_req_i,
    input  mem_pkg::addr_t     dbus_addr_i,
    input  mem_pkg::word_t     dbus_wdata_i,
    input  logic               dbus_wen_i,
    input  mem_pkg::byte_sel_t dbus_byte_sel_i,
    input  logic               dmem_sel_i,
    input  logic               bmem_sel_i,
    output logic               dbus_ack_o,
    output mem_pkg::word_t     dbus_rdata_o,
    output logic               bmem_ack_o,
    output mem_pkg::word_t     bmem_rdata_o,

    // Page walker
    input  logic               mmu_req_i,
    input  mem_pkg::addr_t     mmu_paddr_i,
    output logic               mmu_valid_o,
    output mem_pkg::word_t     mmu_rdata_o
);

    logic               data_req, data_wen, data_ack;
    mem_pkg::addr_t     data_addr;
    mem_pkg::word_t     data_wdata, data_rdata;
    mem_pkg::byte_sel_t data_byte_sel;

    logic               mem_req, mem_wen, mem_ack;
    mem_pkg::addr_t     mem_addr;
    mem_pkg::word_t     mem_wdata, mem_rdata;
    mem_pkg::byte_sel_t mem_byte_sel;

    logic               boot_match, instr_req, instr_ack, boot_fetch_ack;
    mem_pkg::word_t     instr_rdata, boot_fetch_rdata;

    // Boot region fetches never reach main memory
    assign boot_match =
        (fetch_addr_i[mem_pkg::BOOT_SEL_HIGH:mem_pkg::BOOT_SEL_LOW] == mem_pkg::BOOT_ADDR_MATCH);
    assign instr_req  = fetch_req_i & ~boot_match;

    data_port_arbiter u_data_port_arbiter (
        .clk (clk), .rst_n (rst_n),
        .dbus_req_i (dbus_req_i), .dmem_sel_i (dmem_sel_i),
        .dbus_addr_i (dbus_addr_i), .dbus_wdata_i (dbus_wdata_i),
        .dbus_wen_i (dbus_wen_i), .dbus_byte_sel_i (dbus_byte_sel_i),
        .dbus_ack_o (dbus_ack_o), .dbus_rdata_o (dbus_rdata_o),
        .mmu_req_i (mmu_req_i), .mmu_paddr_i (mmu_paddr_i),
        .mmu_valid_o (mmu_valid_o), .mmu_rdata_o (mmu_rdata_o),
        .data_req_o (data_req), .data_addr_o (data_addr),
        .data_wdata_o (data_wdata), .data_wen_o (data_wen),
        .data_byte_sel_o (data_byte_sel),
        .data_ack_i (data_ack), .data_rdata_i (data_rdata)
    );

    boot_mem u_boot_mem (
        .clk (clk), .rst_n (rst_n),
        .dbus_req_i (dbus_req_i), .bmem_sel_i (bmem_sel_i),
        .dbus_addr_i (dbus_addr_i), .dbus_wdata_i (dbus_wdata_i),
        .dbus_wen_i (dbus_wen_i), .dbus_byte_sel_i (dbus_byte_sel_i),
        .bmem_ack_o (bmem_ack_o), .bmem_rdata_o (bmem_rdata_o),
        .fetch_req_i (fetch_req_i), .fetch_addr_i (fetch_addr_i),
        .fetch_ack_o (boot_fetch_ack), .fetch_rdata_o (boot_fetch_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk (clk), .rst_n (rst_n),
        .data_req_i (data_req), .data_addr_i (data_addr),
        .data_wdata_i (data_wdata), .data_wen_i (data_wen),
        .data_byte_sel_i (data_byte_sel),
        .data_ack_o (data_ack), .data_rdata_o (data_rdata),
        .instr_req_i (instr_req), .instr_addr_i (fetch_addr_i),
        .instr_kill_i (fetch_kill_i),
        .instr_ack_o (instr_ack), .instr_rdata_o (instr_rdata),
        .mem_req_o (mem_req), .mem_addr_o (mem_addr),
        .mem_wdata_o (mem_wdata), .mem_wen_o (mem_wen),
        .mem_byte_sel_o (mem_byte_sel),
        .mem_ack_i (mem_ack), .mem_rdata_i (mem_rdata)
    );

    main_mem u_main_mem (
        .clk (clk), .rst_n (rst_n),
        .mem_req_i (mem_req), .mem_addr_i (mem_addr),
        .mem_wdata_i (mem_wdata), .mem_wen_i (mem_wen),
        .mem_byte_sel_i (mem_byte_sel),
        .mem_ack_o (mem_ack), .mem_rdata_o (mem_rdata)
    );

    // Only one fetch source is active at a time
    assign fetch_ack_o   = boot_fetch_ack | instr_ack;
    assign fetch_rdata_o = boot_fetch_ack ? boot_fetch_rdata : instr_rdata;

endmodule : mem_top

// File: testbench/mem_top_properties.sv
// Handshake assertions for mem_top, attached to every mem_top instance with bind
`timescale 1ns/1ps

module mem_top_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           fetch_ack_i,
    input logic           dbus_ack_i,
    input logic           bmem_ack_i,
    input logic           mmu_valid_i,
    input logic           mem_req_i,
    input mem_pkg::addr_t mem_addr_i,
    input mem_pkg::word_t mem_wdata_i,
    input logic           mem_wen_i,
    input logic           mem_ack_i
);

    logic [3:0] since_rst;
    logic       pending_ff;
    logic       new_req;
    logic       any_ack;

    assign any_ack = fetch_ack_i | dbus_ack_i | bmem_ack_i | mmu_valid_i;

    // A main memory request that is not already waiting for its ack
    assign new_req = mem_req_i & ~pending_ff;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            since_rst  <= '0;
            pending_ff <= 1'b0;
        end else begin
            if (since_rst < 4'd8) begin
                since_rst <= since_rst + 4'd1;
            end
            pending_ff <= (pending_ff & ~mem_ack_i) | new_req;
        end
    end

    quiet_after_reset: assert property (@(posedge clk) (since_rst < 4'd8) |-> !any_ack)
        else $error("ack seen within 8 cycles of reset");

    fetch_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ack_i |=> !fetch_ack_i) else $error("fetch ack longer than one cycle");
    dbus_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_ack_i |=> !dbus_ack_i) else $error("dbus ack longer than one cycle");
    bmem_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bmem_ack_i |=> !bmem_ack_i) else $error("bmem ack longer than one cycle");
    mmu_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mmu_valid_i |=> !mmu_valid_i) else $error("mmu valid longer than one cycle");

    // Request held with the same address and data up to the ack
    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_i && !mem_ack_i) |=> (mem_ack_i || (mem_req_i && $stable(mem_addr_i) &&
        $stable(mem_wdata_i) && $stable(mem_wen_i))))
        else $error("mem_req dropped or changed before its ack");

    mem_latency: assert property (@(posedge clk) disable iff (!rst_n)
        new_req |-> ##(mem_pkg::MEM_LATENCY) mem_ack_i)
        else $error("main memory ack not at the fixed latency");

endmodule : mem_top_properties

bind mem_top mem_top_properties u_props (
    .clk (clk), .rst_n (rst_n),
    .fetch_ack_i (fetch_ack_o), .dbus_ack_i (dbus_ack_o),
    .bmem_ack_i (bmem_ack_o), .mmu_valid_i (mmu_valid_o),
    .mem_req_i (mem_req), .mem_addr_i (mem_addr),
    .mem_wdata_i (mem_wdata), .mem_wen_i (mem_wen),
    .mem_ack_i (mem_ack)
);

// File: testbench/mem_top_tb.sv
// Testbench for mem_top, runs the directed patterns file and then random write/read pairs
`timescale 1ns/1ps

module mem_top_tb;

    localparam int TIMEOUT = 50;
    localparam int NPAT    = 32;

    logic               clk;
    logic               rst_n;
    logic               fetch_req, fetch_kill, dbus_req, dbus_wen, dmem_sel, bmem_sel, mmu_req;
    mem_pkg::addr_t     fetch_addr, dbus_addr, mmu_paddr;
    mem_pkg::word_t     dbus_wdata;
    mem_pkg::byte_sel_t dbus_byte_sel;
    logic               fetch_ack_o, dbus_ack_o, bmem_ack_o, mmu_valid_o;
    mem_pkg::word_t     fetch_rdata_o, dbus_rdata_o, bmem_rdata_o, mmu_rdata_o;

    int             errors;
    int             timeouts;
    int             cycle;
    logic [31:0]    pat [0:5*NPAT-1];
    mem_pkg::word_t model [mem_pkg::MEM_WORDS];
    logic [31:0]    rng;

    mem_top u_dut (
        .clk (clk), .rst_n (rst_n),
        .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr), .fetch_kill_i (fetch_kill),
        .fetch_ack_o (fetch_ack_o), .fetch_rdata_o (fetch_rdata_o),
        .dbus_req_i (dbus_req), .dbus_addr_i (dbus_addr), .dbus_wdata_i (dbus_wdata),
        .dbus_wen_i (dbus_wen), .dbus_byte_sel_i (dbus_byte_sel),
        .dmem_sel_i (dmem_sel), .bmem_sel_i (bmem_sel),
        .dbus_ack_o (dbus_ack_o), .dbus_rdata_o (dbus_rdata_o),
        .bmem_ack_o (bmem_ack_o), .bmem_rdata_o (bmem_rdata_o),
        .mmu_req_i (mmu_req), .mmu_paddr_i (mmu_paddr),
        .mmu_valid_o (mmu_valid_o), .mmu_rdata_o (mmu_rdata_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Byte i of the result comes from the new word when mask bit i is set
    function automatic mem_pkg::word_t merge_bytes(input mem_pkg::word_t old_w,
                                                   input mem_pkg::word_t new_w,
                                                   input mem_pkg::byte_sel_t mask);
        mem_pkg::word_t r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                r[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return r;
    endfunction

    task automatic check_word(input string name, input mem_pkg::word_t exp,
                              input mem_pkg::word_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic lsu_access(input mem_pkg::addr_t addr, input mem_pkg::word_t wdata,
                              input logic wen, input mem_pkg::byte_sel_t sel,
                              input logic to_boot, output mem_pkg::word_t rdata,
                              output int ack_cycle);
        int   n;
        logic got;
        n = 0;
        got = 1'b0;
        rdata = '0;
        ack_cycle = 0;
        @(posedge clk);
        dbus_req      <= 1'b1;
        dbus_addr     <= addr;
        dbus_wdata    <= wdata;
        dbus_wen      <= wen;
        dbus_byte_sel <= sel;
        dmem_sel      <= !to_boot;
        bmem_sel      <= to_boot;
        while (!got && n < TIMEOUT) begin
            @(negedge clk);
            if (to_boot ? bmem_ack_o : dbus_ack_o) begin
                got = 1'b1;
                rdata = to_boot ? bmem_rdata_o : dbus_rdata_o;
                ack_cycle = cycle;
            end
            n++;
        end
        @(posedge clk);
        dbus_req <= 1'b0;
        dbus_wen <= 1'b0;
        dmem_sel <= 1'b0;
        bmem_sel <= 1'b0;
        if (!got) begin
            $display("Timeout: load/store access to %h was never acknowledged", addr);
            timeouts++;
        end
    endtask

    task automatic mmu_read(input mem_pkg::addr_t addr, input logic alone,
                            output mem_pkg::word_t rdata, output int ack_cycle);
        int   n;
        logic got;
        n = 0;
        got = 1'b0;
        rdata = '0;
        ack_cycle = 0;
        @(posedge clk);
        mmu_req   <= 1'b1;
        mmu_paddr <= addr;
        while (!got && n < TIMEOUT) begin
            @(negedge clk);
            if (alone && dbus_ack_o) begin
                $display("Walker read at %h raised the load/store ack", addr);
                errors++;
            end
            if (mmu_valid_o) begin
                got = 1'b1;
                rdata = mmu_rdata_o;
                ack_cycle = cycle;
            end
            n++;
        end
        @(posedge clk);
        mmu_req <= 1'b0;
        if (!got) begin
            $display("Timeout: walker read of %h never became valid", addr);
            timeouts++;
        end
    endtask

    task automatic fetch_read(input mem_pkg::addr_t addr, output mem_pkg::word_t rdata,
                              output int waited);
        logic got;
        waited = 0;
        got = 1'b0;
        rdata = '0;
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        while (!got && waited < TIMEOUT) begin
            @(negedge clk);
            if (fetch_ack_o) begin
                got = 1'b1;
                rdata = fetch_rdata_o;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        if (!got) begin
            $display("Timeout: fetch of %h was never acknowledged", addr);
            timeouts++;
        end
    endtask

    // Raise a fetch, kill it while main memory is busy, then watch for a stray ack
    task automatic fetch_killed(input mem_pkg::addr_t addr);
        @(posedge clk);
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        @(posedge clk);
        fetch_kill <= 1'b1;
        @(posedge clk);
        fetch_kill <= 1'b0;
        fetch_req  <= 1'b0;
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            if (fetch_ack_o) begin
                $display("Killed fetch of %h still produced a fetch ack", addr);
                errors++;
            end
        end
    endtask

    initial begin
        mem_pkg::word_t rd;
        mem_pkg::word_t rd2;
        mem_pkg::addr_t addr;
        mem_pkg::word_t wd;
        logic [31:0]    op;
        int             c1;
        int             c2;
        int             k;
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_req = 1'b0;
        fetch_kill = 1'b0;
        fetch_addr = '0;
        dbus_req = 1'b0;
        dbus_addr = '0;
        dbus_wdata = '0;
        dbus_wen = 1'b0;
        dbus_byte_sel = '0;
        dmem_sel = 1'b0;
        bmem_sel = 1'b0;
        mmu_req = 1'b0;
        mmu_paddr = '0;
        errors = 0;
        timeouts = 0;
        cycle = 0;
        rng = 32'd53083;
        $readmemh("testbench/mem_patterns.txt", pat);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // Keep the ports quiet for a while after reset
        repeat (8) @(posedge clk);

        for (int i = 0; i < NPAT; i++) begin
            op   = pat[5*i];
            addr = pat[5*i+1];
            wd   = pat[5*i+2];
            if (op == 32'h0 || op == 32'hf) begin
                break;
            end
            case (op)
                32'h1: begin
                    lsu_access(addr, wd, 1'b1, pat[5*i+3][3:0], 1'b0, rd, c1);
                    model[addr[11:2]] = merge_bytes(model[addr[11:2]], wd, pat[5*i+3][3:0]);
                end
                32'h2: begin
                    lsu_access(addr, '0, 1'b0, 4'hf, 1'b0, rd, c1);
                    check_word("lsu_read", pat[5*i+4], rd);
                end
                32'h3: begin
                    mmu_read(addr, 1'b1, rd, c1);
                    check_word("walker_read", pat[5*i+4], rd);
                end
                32'h4: begin
                    lsu_access(addr, wd, 1'b1, pat[5*i+3][3:0], 1'b1, rd, c1);
                end
                32'h5: begin
                    fetch_read(addr, rd, c1);
                    check_word("fetch", pat[5*i+4], rd);
                    if (addr[31:28] == 4'h1) begin
                        if (c1 != 1) begin
                            $display("ERROR boot_fetch_latency expected 1 actual %0d", c1);
                            errors++;
                        end
                        // The data bus sees the same boot word
                        lsu_access(addr, '0, 1'b0, 4'hf, 1'b1, rd2, c2);
                        check_word("boot_data_read", pat[5*i+4], rd2);
                    end
                end
                32'h6: begin
                    fetch_killed(addr);
                    fork
                        fetch_read(addr, rd, c1);
                        lsu_access(32'h40, '0, 1'b0, 4'hf, 1'b0, rd2, c2);
                    join
                    check_word("fetch_after_kill", pat[5*i+4], rd);
                    check_word("data_beside_fetch", model[16], rd2);
                end
                default: begin
                    $display("Unknown operation code %h in pattern line %0d", op, i);
                    errors++;
                end
            endcase
        end

        // Load/store and walker raised in the same cycle
        fork
            lsu_access(32'h40, '0, 1'b0, 4'hf, 1'b0, rd, c1);
            mmu_read(32'h80, 1'b0, rd2, c2);
        join
        check_word("same_cycle_lsu", model[16], rd);
        check_word("same_cycle_walker", model[32], rd2);
        if (c1 >= c2) begin
            $display("ERROR ack_order expected lsu first, lsu cycle %0d walker cycle %0d",
                     c1, c2);
            errors++;
        end

        // Full-word fill so later partial writes merge onto known bytes
        for (int j = 0; j < 16; j++) begin
            addr = 32'h200 + 32'(j * 4);
            wd = addr ^ 32'hc3a5_9e17;
            lsu_access(addr, wd, 1'b1, 4'hf, 1'b0, rd, c1);
            model[addr[11:2]] = wd;
        end
        for (int j = 0; j < 32; j++) begin
            rng = xorshift(rng);
            k = int'(rng[3:0]);
            addr = 32'h200 + 32'(k * 4);
            rng = xorshift(rng);
            wd = rng;
            rng = xorshift(rng);
            lsu_access(addr, wd, 1'b1, rng[3:0], 1'b0, rd, c1);
            model[addr[11:2]] = merge_bytes(model[addr[11:2]], wd, rng[3:0]);
            lsu_access(addr, '0, 1'b0, 4'hf, 1'b0, rd, c1);
            check_word("random_read", model[addr[11:2]], rd);
        end

        $display("Run complete with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : mem_top_tb

// File: testbench/mem_patterns.txt
// op addr wdata mask expected, all hex, one operation per line
// op 1 lsu write, 2 lsu read, 3 walker read, 4 boot write, 5 fetch, 6 killed fetch, f end
1 00000040 11223344 f 00000000
2 00000040 00000000 f 11223344
1 00000040 aabbccdd 5 00000000
2 00000040 00000000 f 11bb33dd
3 00000040 00000000 f 11bb33dd
1 000000c0 01020304 f 00000000
1 000000c0 a0b0c0d0 8 00000000
2 000000c0 00000000 f a0020304
3 000000c0 00000000 f a0020304
1 00000080 cafe0001 f 00000000
5 00000080 00000000 f cafe0001
4 10000010 deadbeef f 00000000
5 10000010 00000000 f deadbeef
4 10000010 00005500 2 00000000
5 10000010 00000000 f dead55ef
6 00000080 00000000 f cafe0001
3 00000080 00000000 f cafe0001
f 00000000 00000000 0 00000000

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module mem_top_tb \
    -o mem_top_sim
./obj_dir/mem_top_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

// File: verilog.f
common/mem_pkg.sv
logic/data_port_arbiter.sv
logic/boot_mem.sv
mem_arbiter/mem_arbiter.sv
logic/main_mem.sv
logic/mem_top.sv
testbench/mem_top_properties.sv
testbench/mem_top_tb.sv
